// File: Bender.yml
package:
  name: scan_count

sources:
  - logic/scan_count_pkg.sv
  - logic/beat_buffer.sv
  - logic/predicate_lane_group.sv
  - logic/match_accumulator.sv
  - logic/scan_count.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/scan_count_tb.sv

// File: logic/beat_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module beat_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  scan_count_pkg::beat_t in_beat,
  output logic                  pop_valid,
  output scan_count_pkg::beat_t pop_beat,
  output logic                  credit_return
);

  // Beat storage.
  scan_count_pkg::beat_t mem [scan_count_pkg::buffer_depth];

  logic [scan_count_pkg::buffer_ptr_width-1:0]   wr_ptr;
  logic [scan_count_pkg::buffer_ptr_width-1:0]   rd_ptr;
  logic [scan_count_pkg::buffer_count_width-1:0] count;
  logic                                          do_pop;

  // Pointer advance with wrap at the last entry.
  function automatic logic [scan_count_pkg::buffer_ptr_width-1:0] next_ptr(
    input logic [scan_count_pkg::buffer_ptr_width-1:0] ptr
  );
    logic [scan_count_pkg::buffer_ptr_width-1:0] nxt;
    if (ptr == scan_count_pkg::buffer_depth - 1) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Drain one beat every cycle while anything is stored.
  assign do_pop = (count != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= do_pop;
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({in_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and output beat carry no reset.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_beat;
    end
    if (do_pop) begin
      pop_beat <= mem[rd_ptr];
    end
  end

  // Every beat handed on frees its entry, so one credit goes back with it.
  assign credit_return = pop_valid;

  // The sender must never spend a credit it does not own.
  assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (count < scan_count_pkg::buffer_depth))
    else $error("beat_buffer: write while full, sender exceeded its credits");

endmodule

`default_nettype wire

// File: logic/match_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module match_accumulator (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  clr,
  input  scan_count_pkg::group_count_t          low_count,
  input  scan_count_pkg::group_count_t          high_count,
  output logic                                  done,
  output logic [scan_count_pkg::count_width-1:0] result_count
);

  logic [scan_count_pkg::count_width-1:0] low_ext;
  logic [scan_count_pkg::count_width-1:0] high_ext;
  logic [scan_count_pkg::count_width-1:0] pair_sum;
  logic [scan_count_pkg::count_width-1:0] sum_q;
  logic [scan_count_pkg::count_width-1:0] total;
  logic                                   pair_valid;
  logic                                   pair_last;

  // Both groups run in lockstep, so the low flags stand for the pair.
  assign pair_valid = low_count.valid;
  assign pair_last  = low_count.valid & low_count.last;

  assign low_ext  = {{(scan_count_pkg::count_width - scan_count_pkg::group_count_width){1'b0}},
                     low_count.count};
  assign high_ext = {{(scan_count_pkg::count_width - scan_count_pkg::group_count_width){1'b0}},
                     high_count.count};
  assign pair_sum = low_ext + high_ext;

  // Running sum including the current pair.
  assign total = sum_q + pair_sum;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_q <= '0;
      done  <= 1'b0;
    end else begin
      done <= pair_last;
      if (clr) begin
        sum_q <= '0;
      end else if (pair_last) begin
        // Packet finished, start the next one from zero.
        sum_q <= '0;
      end else if (pair_valid) begin
        sum_q <= total;
      end
    end
  end

  // Total is held until the next packet completes.
  always_ff @(posedge clk) begin
    if (pair_last) begin
      result_count <= total;
    end
  end

  // The two lane groups must agree beat for beat.
  assert property (@(posedge clk) disable iff (!rst_n)
    (low_count.valid == high_count.valid) &&
    (!low_count.valid || (low_count.last == high_count.last)))
    else $error("match_accumulator: lane groups out of lockstep");

  // Clearing is only allowed between packets.
  assert property (@(posedge clk) disable iff (!rst_n)
    clr |-> !low_count.valid)
    else $error("match_accumulator: clr during a packet");

endmodule

`default_nettype wire

// File: logic/predicate_lane_group.sv
`timescale 1ns/1ps
`default_nettype none

module predicate_lane_group (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   beat_valid,
  input  logic                                   beat_last,
  input  logic [scan_count_pkg::words_per_group-1:0]
               [scan_count_pkg::word_width-1:0]  words,
  input  scan_count_pkg::cmp_op_e                cmp_op,
  input  logic [scan_count_pkg::word_width-1:0]  cmp_value,
  output scan_count_pkg::group_count_t           group_count
);

  // Raw unsigned comparisons.
  logic [scan_count_pkg::words_per_group-1:0] lt_w;
  logic [scan_count_pkg::words_per_group-1:0] eq_w;

  // Stage one: all six predicates per word.
  logic                                       s1_valid;
  logic                                       s1_last;
  logic [scan_count_pkg::words_per_group-1:0] s1_eq;
  logic [scan_count_pkg::words_per_group-1:0] s1_ne;
  logic [scan_count_pkg::words_per_group-1:0] s1_lt;
  logic [scan_count_pkg::words_per_group-1:0] s1_le;
  logic [scan_count_pkg::words_per_group-1:0] s1_gt;
  logic [scan_count_pkg::words_per_group-1:0] s1_ge;

  // Stage two: selected bits and their count.
  logic [scan_count_pkg::words_per_group-1:0]   sel;
  logic                                         s2_valid;
  logic                                         s2_last;
  logic [scan_count_pkg::group_count_width-1:0] s2_count;

  function automatic logic [scan_count_pkg::group_count_width-1:0] ones(
    input logic [scan_count_pkg::words_per_group-1:0] bits
  );
    logic [scan_count_pkg::group_count_width-1:0] n;
    n = '0;
    for (int i = 0; i < scan_count_pkg::words_per_group; i++) begin
      n = n + {{(scan_count_pkg::group_count_width-1){1'b0}}, bits[i]};
    end
    return n;
  endfunction

  always_comb begin
    for (int i = 0; i < scan_count_pkg::words_per_group; i++) begin
      lt_w[i] = (words[i] < cmp_value);
      eq_w[i] = (words[i] == cmp_value);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= beat_valid;
      s1_last  <= beat_valid & beat_last;
    end
  end

  // Everything else follows from less and equal.
  always_ff @(posedge clk) begin
    s1_eq <= eq_w;
    s1_ne <= ~eq_w;
    s1_lt <= lt_w;
    s1_le <= lt_w | eq_w;
    s1_gt <= ~(lt_w | eq_w);
    s1_ge <= ~lt_w;
  end

  always_comb begin
    case (cmp_op)
      scan_count_pkg::op_eq: sel = s1_eq;
      scan_count_pkg::op_ne: sel = s1_ne;
      scan_count_pkg::op_lt: sel = s1_lt;
      scan_count_pkg::op_le: sel = s1_le;
      scan_count_pkg::op_gt: sel = s1_gt;
      scan_count_pkg::op_ge: sel = s1_ge;
      // reserved codes
      default:               sel = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    s2_count <= ones(sel);
  end

  assign group_count = '{count: s2_count, valid: s2_valid, last: s2_last};

endmodule

`default_nettype wire

// File: logic/scan_count.sv
`timescale 1ns/1ps
`default_nettype none

module scan_count (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   clr,
  input  scan_count_pkg::cmp_op_e                cmp_op,
  input  logic [scan_count_pkg::word_width-1:0]  cmp_value,
  input  logic                                   in_valid,
  input  scan_count_pkg::beat_t                  in_beat,
  output logic                                   credit_return,
  output logic                                   done,
  output logic [scan_count_pkg::count_width-1:0] result_count
);

  logic                         pop_valid;
  scan_count_pkg::beat_t        pop_beat;
  scan_count_pkg::group_count_t low_count;
  scan_count_pkg::group_count_t high_count;

  // Words 0 to 7 go low, 8 to 15 go high.
  logic [scan_count_pkg::words_per_group-1:0][scan_count_pkg::word_width-1:0] low_words;
  logic [scan_count_pkg::words_per_group-1:0][scan_count_pkg::word_width-1:0] high_words;

  assign low_words  = pop_beat.data[scan_count_pkg::words_per_group-1:0];
  assign high_words = pop_beat.data[scan_count_pkg::words_per_beat-1:
                                    scan_count_pkg::words_per_group];

  beat_buffer buffer0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_beat       (in_beat),
    .pop_valid     (pop_valid),
    .pop_beat      (pop_beat),
    .credit_return (credit_return)
  );

  predicate_lane_group low_group (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat_valid  (pop_valid),
    .beat_last   (pop_beat.last),
    .words       (low_words),
    .cmp_op      (cmp_op),
    .cmp_value   (cmp_value),
    .group_count (low_count)
  );

  predicate_lane_group high_group (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat_valid  (pop_valid),
    .beat_last   (pop_beat.last),
    .words       (high_words),
    .cmp_op      (cmp_op),
    .cmp_value   (cmp_value),
    .group_count (high_count)
  );

  match_accumulator accum0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .clr          (clr),
    .low_count    (low_count),
    .high_count   (high_count),
    .done         (done),
    .result_count (result_count)
  );

endmodule

`default_nettype wire

// File: logic/scan_count_pkg.sv
`default_nettype none

package scan_count_pkg;

  // Beat geometry.
  localparam int word_width      = 32;
  localparam int words_per_beat  = 16;
  localparam int words_per_group = 8;

  // Input buffer depth, which is also the sender's credit budget after reset.
  localparam int buffer_depth        = 4;
  localparam int buffer_ptr_width    = $clog2(buffer_depth);
  localparam int buffer_count_width  = $clog2(buffer_depth + 1);

  // Width of a per-group match count, holding 0 to words_per_group.
  localparam int group_count_width = $clog2(words_per_group + 1);

  // Width of the packet total.
  localparam int count_width = 32;

  // Comparison applied to every word against the reference value.
  // Codes 6 and 7 are reserved and match nothing.
  typedef enum logic [2:0] {
    op_eq = 3'd0,
    op_ne = 3'd1,
    op_lt = 3'd2,
    op_le = 3'd3,
    op_gt = 3'd4,
    op_ge = 3'd5
  } cmp_op_e;

  // One input beat, 513 bits.
  typedef struct packed {
    logic [words_per_beat-1:0][word_width-1:0] data;
    logic                                      last;
  } beat_t;

  // Partial count from one lane group, 6 bits.
  typedef struct packed {
    logic [group_count_width-1:0] count;
    logic                         valid;
    logic                         last;
  } group_count_t;

endpackage

`default_nettype wire

// File: scan_count.f
+incdir+tb
logic/scan_count_pkg.sv
logic/beat_buffer.sv
logic/predicate_lane_group.sv
logic/match_accumulator.sv
logic/scan_count.sv
tb/scan_count_tb.sv

// File: tb/scan_count_model.svh
`ifndef scan_count_model_svh
`define scan_count_model_svh

`default_nettype none

// Unsigned comparison of one word against the reference.
// Codes 0 to 5 are eq, ne, lt, le, gt, ge; 6 and 7 match nothing.
function automatic bit word_matches(
  input logic [2:0]                             op,
  input logic [scan_count_pkg::word_width-1:0] value,
  input logic [scan_count_pkg::word_width-1:0] word
);
  bit hit;
  case (op)
    3'd0:    hit = (word == value);
    3'd1:    hit = (word != value);
    3'd2:    hit = (word < value);
    3'd3:    hit = (word <= value);
    3'd4:    hit = (word > value);
    3'd5:    hit = (word >= value);
    default: hit = 1'b0;
  endcase
  return hit;
endfunction

// Number of matching words in one full beat.
function automatic int beat_match_count(
  input logic [2:0]                             op,
  input logic [scan_count_pkg::word_width-1:0] value,
  input scan_count_pkg::beat_t                  beat
);
  int n;
  n = 0;
  for (int i = 0; i < scan_count_pkg::words_per_beat; i++) begin
    if (word_matches(op, value, beat.data[i])) begin
      n++;
    end
  end
  return n;
endfunction

`default_nettype wire

`endif

// File: tb/scan_count_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scan_count_tb;

  `include "scan_count_model.svh"

  logic                                   clk;
  logic                                   rst_n;
  logic                                   clr;
  scan_count_pkg::cmp_op_e                cmp_op;
  logic [scan_count_pkg::word_width-1:0]  cmp_value;
  logic                                   in_valid;
  scan_count_pkg::beat_t                  in_beat;
  logic                                   credit_return;
  logic                                   done;
  logic [scan_count_pkg::count_width-1:0] result_count;

  integer seed;
  int     credits;
  int     beats_sent;
  int     returns_seen;
  int     value_errors;
  int     other_errors;
  int     expected_totals[$];

  scan_count dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .clr           (clr),
    .cmp_op        (cmp_op),
    .cmp_value     (cmp_value),
    .in_valid      (in_valid),
    .in_beat       (in_beat),
    .credit_return (credit_return),
    .done          (done),
    .result_count  (result_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input longint got, input longint expected, input string what);
    if (got !== expected) begin
      $display("[FAIL] %0t: %s: got %0d, expected %0d", $time, what, got, expected);
      value_errors++;
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Mostly values at or next to the reference, so equality edges come up often.
  function automatic logic [31:0] random_word(input logic [31:0] value);
    logic [31:0] w;
    case (rand_below(5))
      0:       w = value;
      1:       w = value + 1;
      2:       w = value - 1;
      3:       w = value ^ (32'd1 << rand_below(32));
      default: w = $random(seed);
    endcase
    return w;
  endfunction

  // Every cycle goes through here, so no credit_return pulse is missed.
  task automatic next_cycle();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    clr      = 1'b0;
    if (credit_return === 1'b1) begin
      credits++;
      returns_seen++;
    end
  endtask

  task automatic send_beat(input scan_count_pkg::beat_t beat);
    int waited;
    waited = 0;
    while (credits == 0) begin
      next_cycle();
      waited++;
      if (waited > 50) begin
        other_errors++;
        $display("Timeout: the DUT returned no credit for 50 cycles");
        finish_run();
      end
    end
    in_valid = 1'b1;
    in_beat  = beat;
    credits--;
    beats_sent++;
    next_cycle();
  endtask

  task automatic send_packet(input int beats, input int max_gap);
    scan_count_pkg::beat_t beat;
    int                    total;
    total = 0;
    for (int b = 0; b < beats; b++) begin
      repeat (rand_below(max_gap + 1)) next_cycle();
      for (int w = 0; w < scan_count_pkg::words_per_beat; w++) begin
        beat.data[w] = random_word(cmp_value);
      end
      beat.last = (b == beats - 1);
      total += beat_match_count(cmp_op, cmp_value, beat);
      send_beat(beat);
    end
    expected_totals.push_back(total);
  endtask

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (expected_totals.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > 100) begin
        other_errors++;
        $display("Timeout: done never arrived for %0d outstanding packets",
                 expected_totals.size());
        finish_run();
      end
    end
    repeat (2) next_cycle();
  endtask

  // Op and value stay fixed until every packet of the round has finished.
  task automatic run_round(input logic [2:0] op, input logic [31:0] value,
                           input int packets, input int max_gap, input bit burst);
    cmp_op    = scan_count_pkg::cmp_op_e'(op);
    cmp_value = value;
    for (int p = 0; p < packets; p++) begin
      send_packet(burst ? 6 : 1 + rand_below(6), max_gap);
    end
    wait_for_done();
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (8) next_cycle();
    rst_n   = 1'b1;
    credits = scan_count_pkg::buffer_depth;
  endtask

  // Each done is matched against the oldest outstanding packet.
  always @(negedge clk) begin
    if (rst_n === 1'b1 && done === 1'b1) begin
      if (expected_totals.size() == 0) begin
        other_errors++;
        $display("Error at %0t: done pulsed with no packet outstanding", $time);
      end else begin
        check_value(result_count, expected_totals.pop_front(), "packet total");
      end
    end
  end

  initial begin
    seed         = 40;
    rst_n        = 1'b0;
    clr          = 1'b0;
    cmp_op       = scan_count_pkg::op_eq;
    cmp_value    = '0;
    in_valid     = 1'b0;
    in_beat      = '0;
    credits      = scan_count_pkg::buffer_depth;
    beats_sent   = 0;
    returns_seen = 0;
    value_errors = 0;
    other_errors = 0;

    apply_reset();
    // Idle after reset. Any done here is flagged by the monitor.
    repeat (20) next_cycle();

    // All opcodes, reserved ones included, at both ends of the range.
    for (int op = 0; op < 8; op++) begin
      run_round(3'(op), 32'd0, 3, 3, 1'b0);
      run_round(3'(op), '1, 3, 3, 1'b0);
      run_round(3'(op), $random(seed), 3, 3, 1'b0);
      clr = 1'b1;
      next_cycle();
    end

    // Gapless bursts keep all credits in use and several beats in flight.
    run_round(3'd5, $random(seed), 4, 0, 1'b1);
    run_round(3'd0, $random(seed), 4, 0, 1'b1);

    check_value(returns_seen, beats_sent, "credit returns against beats sent");
    check_value(credits, scan_count_pkg::buffer_depth, "credits after drain");

    // A second reset between packets, then more traffic.
    apply_reset();
    repeat (20) next_cycle();
    run_round(3'd2, $random(seed), 2, 2, 1'b0);
    run_round(3'd4, $random(seed), 2, 0, 1'b1);

    check_value(returns_seen, beats_sent, "credit returns against beats sent");
    check_value(credits, scan_count_pkg::buffer_depth, "credits after drain");
    finish_run();
  end

endmodule

`default_nettype wire
